/* hdl/irq_pkg.sv */
// Board interrupt controller definitions
// Interrupt source positions, board input widths, synchronizer depth
// and the debounce length of the external alarm path
`default_nettype none

package irq_pkg;

    // Board input widths
    localparam int N_ANTENNAS = 8;
    localparam int N_ALARMS   = 4;
    localparam int N_SFP      = 2;

    typedef logic [N_ANTENNAS-1:0] antenna_vec_t;
    typedef logic [N_ALARMS-1:0]   alarm_vec_t;
    typedef logic [N_SFP-1:0]      sfp_vec_t;

    // Interrupt sources, one sticky bit each
    localparam int N_IRQ          = 5;
    localparam int IRQ_ADC_DAC    = 0;
    localparam int IRQ_ADC_THRESH = 1;
    localparam int IRQ_EXT_ALARM  = 2;
    localparam int IRQ_SFP        = 3;
    localparam int IRQ_PSU        = 4;

    typedef logic [N_IRQ-1:0] irq_vec_t;

    // Input conditioning
    localparam int SYNC_STAGES     = 2;
    localparam int DEBOUNCE_CYCLES = 16;

    typedef logic [$clog2(DEBOUNCE_CYCLES+1)-1:0] debounce_cnt_t;

endpackage

`default_nettype wire

/* hdl/regmap_pkg.sv */
// Register map of the board interrupt controller
// Bus widths, register addresses and reset values
`default_nettype none

package regmap_pkg;

    typedef logic [7:0]  reg_addr_t;
    typedef logic [31:0] reg_data_t;

    // Sticky bits in [4:0], master interrupt in [31]
    localparam reg_addr_t ADDR_IRQ_STATUS   = 8'h00;
    // A set bit blocks its source
    localparam reg_addr_t ADDR_IRQ_MASK     = 8'h04;
    // Write one to clear, reads zero
    localparam reg_addr_t ADDR_IRQ_CLEAR    = 8'h08;
    // Live alarm, SFP and PSU levels
    localparam reg_addr_t ADDR_BOARD_STATUS = 8'h0C;
    // Live ADC threshold, over-range and over-voltage flags
    localparam reg_addr_t ADDR_ADC_STATUS   = 8'h10;

    // All five sources blocked out of reset
    localparam reg_data_t MASK_RESET = 32'h0000_001F;

    // Master interrupt position in the status word
    localparam int STATUS_MASTER_BIT = 31;

endpackage

`default_nettype wire

/* hdl/intr_ctrl_if.sv */
// Link between the register block and the interrupt collector
// Mask and clear go down to the collector, sticky status comes back
`default_nettype none

interface intr_ctrl_if
    import irq_pkg::*;
();

    // Mask register value, 1 blocks the source
    irq_vec_t irq_mask;
    // Single-cycle clear pulse per source
    irq_vec_t irq_clear;
    // Sticky interrupt bits
    irq_vec_t irq_status;
    // OR of all sticky bits
    logic     irq_master;

    modport regs (
        output irq_mask,
        output irq_clear,
        input  irq_status,
        input  irq_master
    );

    modport collector (
        input  irq_mask,
        input  irq_clear,
        output irq_status,
        output irq_master
    );

endinterface

`default_nettype wire

/* hdl/alarm_debounce.sv */
// Level debouncer
// The output follows the input only once the input has held a new
// level for DEBOUNCE_CYCLES clocks, shorter pulses are dropped
`default_nettype none

module alarm_debounce
    import irq_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic din,
    output logic dout
);

    debounce_cnt_t cnt;
    logic          expire;

    // Input has differed from the output long enough
    assign expire = (din != dout) && (cnt == debounce_cnt_t'(DEBOUNCE_CYCLES - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt  <= '0;
            dout <= 1'b0;
        end else if (din == dout) begin
            cnt <= '0;
        end else if (expire) begin
            cnt  <= '0;
            dout <= din;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // Output only moves on an expired count
    a_dout_after_expire: assert property (
        @(posedge clk) disable iff (rst)
        (dout != $past(dout)) |-> $past(expire)
    );

endmodule

`default_nettype wire

/* hdl/irq_collector.sv */
// Interrupt collector
// Condenses the board inputs into five interrupt sources, keeps one
// sticky bit per source with set-over-clear priority under the mask,
// and drives the master interrupt from the OR of the sticky bits
`default_nettype none

module irq_collector
    import irq_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         irq_adc_dac,
    input  antenna_vec_t adc_threshold1,
    input  antenna_vec_t adc_threshold2,
    input  alarm_vec_t   ext_alarm,
    input  sfp_vec_t     sfp_los,
    input  sfp_vec_t     sfp_tx_fault,
    input  logic         psu_alarm,
    intr_ctrl_if.collector ctrl
);

    logic                   irq_adc_thresh;
    logic                   irq_ext_alarm;
    logic                   irq_ext_alarm_db;
    logic                   irq_sfp;
    logic [SYNC_STAGES-1:0] sfp_sync;
    logic [SYNC_STAGES-1:0] psu_sync;
    irq_vec_t               src_cond;
    irq_vec_t               src_set;
    irq_vec_t               sticky;

    assign irq_adc_thresh = (|adc_threshold1) || (|adc_threshold2);
    assign irq_ext_alarm  = |ext_alarm;
    assign irq_sfp        = (|sfp_los) || (|sfp_tx_fault);

    // SFP and PSU levels come from slow board logic
    always_ff @(posedge clk) begin
        if (rst) begin
            sfp_sync <= '0;
            psu_sync <= '0;
        end else begin
            sfp_sync <= {sfp_sync[SYNC_STAGES-2:0], irq_sfp};
            psu_sync <= {psu_sync[SYNC_STAGES-2:0], psu_alarm};
        end
    end

    alarm_debounce i_alarm_debounce (
        .clk  (clk),
        .rst  (rst),
        .din  (irq_ext_alarm),
        .dout (irq_ext_alarm_db)
    );

    always_comb begin
        src_cond                 = '0;
        // ADC paths are already in this clock domain
        src_cond[IRQ_ADC_DAC]    = irq_adc_dac;
        src_cond[IRQ_ADC_THRESH] = irq_adc_thresh;
        src_cond[IRQ_EXT_ALARM]  = irq_ext_alarm_db;
        src_cond[IRQ_SFP]        = sfp_sync[SYNC_STAGES-1];
        src_cond[IRQ_PSU]        = psu_sync[SYNC_STAGES-1];
    end

    assign src_set = src_cond & ~ctrl.irq_mask;

    // Set wins over a clear in the same cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            sticky <= '0;
        end else begin
            sticky <= (sticky & ~ctrl.irq_clear) | src_set;
        end
    end

    assign ctrl.irq_status = sticky;
    assign ctrl.irq_master = |sticky;

    // Sticky bits only drop after a clear pulse from the register block
    a_fall_needs_clear: assert property (
        @(posedge clk) disable iff (rst)
        ((~ctrl.irq_status & $past(ctrl.irq_status) & ~$past(ctrl.irq_clear)) == '0)
    );

endmodule

`default_nettype wire

/* hdl/intr_ctrl_regs.sv */
// Interrupt control registers
// Mask register, write-one-to-clear pulse, sticky status readback and
// live board and ADC status words behind a registered read mux
`default_nettype none

module intr_ctrl_regs
    import irq_pkg::*;
    import regmap_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         reg_wr,
    input  logic         reg_rd,
    input  reg_addr_t    reg_addr,
    input  reg_data_t    reg_wdata,
    output reg_data_t    reg_rdata,
    input  alarm_vec_t   ext_alarm,
    input  sfp_vec_t     sfp_los,
    input  sfp_vec_t     sfp_tx_fault,
    input  sfp_vec_t     sfp_detect_n,
    input  logic         psu_alarm,
    input  antenna_vec_t adc_threshold1,
    input  antenna_vec_t adc_threshold2,
    input  antenna_vec_t adc_over_range,
    input  antenna_vec_t adc_over_voltage,
    intr_ctrl_if.regs    ctrl
);

    irq_vec_t  mask_q;
    irq_vec_t  clear_q;
    reg_data_t status_word;
    reg_data_t board_word;
    reg_data_t adc_word;
    reg_data_t rd_mux;

    always_ff @(posedge clk) begin
        if (rst) begin
            mask_q <= MASK_RESET[N_IRQ-1:0];
        end else if (reg_wr && reg_addr == ADDR_IRQ_MASK) begin
            mask_q <= reg_wdata[N_IRQ-1:0];
        end
    end

    // Clear bits live for exactly one cycle after the write
    always_ff @(posedge clk) begin
        if (rst) begin
            clear_q <= '0;
        end else if (reg_wr && reg_addr == ADDR_IRQ_CLEAR) begin
            clear_q <= reg_wdata[N_IRQ-1:0];
        end else begin
            clear_q <= '0;
        end
    end

    assign ctrl.irq_mask  = mask_q;
    assign ctrl.irq_clear = clear_q;

    always_comb begin
        status_word                    = reg_data_t'(ctrl.irq_status);
        status_word[STATUS_MASTER_BIT] = ctrl.irq_master;
    end

    // Live levels, straight from the board pins
    assign board_word = reg_data_t'({psu_alarm, sfp_detect_n, sfp_tx_fault,
                                     sfp_los, ext_alarm});
    assign adc_word   = {adc_over_voltage, adc_over_range, adc_threshold2,
                         adc_threshold1};

    always_comb begin
        case (reg_addr)
            ADDR_IRQ_STATUS:   rd_mux = status_word;
            ADDR_IRQ_MASK:     rd_mux = reg_data_t'(mask_q);
            ADDR_BOARD_STATUS: rd_mux = board_word;
            ADDR_ADC_STATUS:   rd_mux = adc_word;
            // Clear register and holes read zero
            default:           rd_mux = '0;
        endcase
    end

    // Read data holds until the next read strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            reg_rdata <= '0;
        end else if (reg_rd) begin
            reg_rdata <= rd_mux;
        end
    end

    a_clear_single_pulse: assert property (
        @(posedge clk) disable iff (rst)
        ((|ctrl.irq_clear) && $past(|ctrl.irq_clear)) |->
            ($past(reg_wr, 1) && $past(reg_wr, 2))
    );

endmodule

`default_nettype wire

/* hdl/board_irq_top.sv */
// Board interrupt controller top level
// Joins the register block and the interrupt collector, drives the
// single interrupt line to the processor
`default_nettype none

module board_irq_top
    import irq_pkg::*;
    import regmap_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         reg_wr,
    input  logic         reg_rd,
    input  reg_addr_t    reg_addr,
    input  reg_data_t    reg_wdata,
    output reg_data_t    reg_rdata,
    input  logic         irq_adc_dac,
    input  antenna_vec_t adc_threshold1,
    input  antenna_vec_t adc_threshold2,
    input  antenna_vec_t adc_over_range,
    input  antenna_vec_t adc_over_voltage,
    input  alarm_vec_t   ext_alarm,
    input  sfp_vec_t     sfp_los,
    input  sfp_vec_t     sfp_tx_fault,
    input  sfp_vec_t     sfp_detect_n,
    input  logic         psu_alarm,
    output logic         pl_ps_irq
);

    intr_ctrl_if i_ctrl_if ();

    intr_ctrl_regs i_intr_ctrl_regs (
        .clk              (clk),
        .rst              (rst),
        .reg_wr           (reg_wr),
        .reg_rd           (reg_rd),
        .reg_addr         (reg_addr),
        .reg_wdata        (reg_wdata),
        .reg_rdata        (reg_rdata),
        .ext_alarm        (ext_alarm),
        .sfp_los          (sfp_los),
        .sfp_tx_fault     (sfp_tx_fault),
        .sfp_detect_n     (sfp_detect_n),
        .psu_alarm        (psu_alarm),
        .adc_threshold1   (adc_threshold1),
        .adc_threshold2   (adc_threshold2),
        .adc_over_range   (adc_over_range),
        .adc_over_voltage (adc_over_voltage),
        .ctrl             (i_ctrl_if.regs)
    );

    irq_collector i_irq_collector (
        .clk            (clk),
        .rst            (rst),
        .irq_adc_dac    (irq_adc_dac),
        .adc_threshold1 (adc_threshold1),
        .adc_threshold2 (adc_threshold2),
        .ext_alarm      (ext_alarm),
        .sfp_los        (sfp_los),
        .sfp_tx_fault   (sfp_tx_fault),
        .psu_alarm      (psu_alarm),
        .ctrl           (i_ctrl_if.collector)
    );

    // Level interrupt, high as long as any sticky bit is set
    assign pl_ps_irq = i_ctrl_if.irq_master;

endmodule

`default_nettype wire

/* testbench/board_irq_tb.sv */
// Testbench for the board interrupt controller
// Drives board inputs and register accesses, tracks the expected
// sticky word in a reference model and compares status reads and the
// interrupt line against it
`default_nettype none

module board_irq_tb
    import irq_pkg::*;
    import regmap_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    logic         clk = 1'b0;
    logic         rst;
    logic         reg_wr;
    logic         reg_rd;
    reg_addr_t    reg_addr;
    reg_data_t    reg_wdata;
    reg_data_t    reg_rdata;
    logic         irq_adc_dac;
    antenna_vec_t adc_threshold1;
    antenna_vec_t adc_threshold2;
    antenna_vec_t adc_over_range;
    antenna_vec_t adc_over_voltage;
    alarm_vec_t   ext_alarm;
    sfp_vec_t     sfp_los;
    sfp_vec_t     sfp_tx_fault;
    sfp_vec_t     sfp_detect_n;
    logic         psu_alarm;
    logic         pl_ps_irq;

    irq_vec_t  exp_sticky;
    irq_vec_t  exp_mask;
    reg_data_t rd_status;
    logic      cmp_req = 1'b0;
    int        errors = 0;
    int        tests_run = 0;
    int        tests_failed = 0;
    int        errors_at_start;
    string     test_name;
    integer    seed = 32'h270d_31f0;

    board_irq_top i_board_irq_top (.*);

    always #4 clk = ~clk;

    // Next sticky word, a set wins over a clear in the same cycle
    function automatic irq_vec_t model_status(input irq_vec_t sticky, input irq_vec_t events,
                                              input irq_vec_t mask, input irq_vec_t clear);
        irq_vec_t nxt;
        int       i;
        nxt = sticky;
        for (i = 0; i < N_IRQ; i++) begin
            if (events[i] && !mask[i]) begin
                nxt[i] = 1'b1;
            end else if (clear[i]) begin
                nxt[i] = 1'b0;
            end
        end
        return nxt;
    endfunction

    function automatic reg_data_t status_word(input irq_vec_t sticky);
        reg_data_t w;
        w = '0;
        w[N_IRQ-1:0] = sticky;
        w[31] = |sticky;
        return w;
    endfunction

    task automatic check_value(input string name, input reg_data_t exp, input reg_data_t got);
        assert (got === exp) else begin
            $display("Fail %s: expected 0x%08h, got 0x%08h", name, exp, got);
            errors++;
        end
    endtask

    // Compares a finished status read and the interrupt line
    always @(negedge clk) begin
        if (cmp_req) begin
            check_value("irq_status", status_word(exp_sticky), rd_status);
            check_value("pl_ps_irq", reg_data_t'(|exp_sticky), reg_data_t'(pl_ps_irq));
            cmp_req <= 1'b0;
        end
    end

    task automatic abort_run(input string what);
        $display("Timeout: %s", what);
        $display("STATUS: FAIL");
        $finish;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) @(negedge clk);
    endtask

    // Bus tasks start and end on a falling edge
    task automatic bus_write(input reg_addr_t addr, input reg_data_t data);
        reg_wr    = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        @(negedge clk);
        reg_wr    = 1'b0;
    endtask

    task automatic bus_read(input reg_addr_t addr, output reg_data_t data);
        reg_rd   = 1'b1;
        reg_addr = addr;
        @(posedge clk);
        @(negedge clk);
        reg_rd   = 1'b0;
        data     = reg_rdata;
    endtask

    task automatic apply_events(input irq_vec_t events, input irq_vec_t clear);
        exp_sticky = model_status(exp_sticky, events, exp_mask, clear);
    endtask

    task automatic set_mask(input irq_vec_t mask);
        bus_write(ADDR_IRQ_MASK, reg_data_t'(mask));
        exp_mask = mask;
    endtask

    task automatic clear_bits(input irq_vec_t bits);
        bus_write(ADDR_IRQ_CLEAR, reg_data_t'(bits));
        apply_events('0, bits);
    endtask

    task automatic check_status();
        int n;
        // One spare cycle so a pending clear has landed
        @(negedge clk);
        bus_read(ADDR_IRQ_STATUS, rd_status);
        cmp_req <= 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (cmp_req && n < 8);
        if (cmp_req) abort_run("compare process did not pick up a status read");
    endtask

    task automatic start_test(input string name);
        test_name       = name;
        errors_at_start = errors;
    endtask

    task automatic finish_test();
        tests_run++;
        if (errors != errors_at_start) begin
            tests_failed++;
            $display("test %s: failed", test_name);
        end else begin
            $display("test %s: ok", test_name);
        end
    endtask

    task automatic drive_sync_source(input int src, input logic level);
        if (src == IRQ_SFP) sfp_tx_fault[0] = level;
        else psu_alarm = level;
    endtask

    // Interrupt line must rise exactly SYNC_STAGES+1 edges after the input
    task automatic sync_edge_test(input int src);
        irq_vec_t only;
        int       k;
        only = irq_vec_t'(1) << src;
        set_mask(~only);
        drive_sync_source(src, 1'b1);
        for (k = 1; k <= SYNC_STAGES + 1; k++) begin
            @(negedge clk);
            check_value("pl_ps_irq", reg_data_t'(k == SYNC_STAGES + 1), reg_data_t'(pl_ps_irq));
        end
        apply_events(only, '0);
        drive_sync_source(src, 1'b0);
        idle(SYNC_STAGES + 2);
        check_status();
        clear_bits('1);
        check_status();
    endtask

    initial begin
        reg_data_t  rd;
        reg_data_t  exp_board;
        reg_data_t  exp_adc;
        logic [31:0] rnd;
        logic [31:0] rnd2;
        int          n;
        logic        seen;

        rst = 1'b1;
        reg_wr = 1'b0;
        reg_rd = 1'b0;
        reg_addr = '0;
        reg_wdata = '0;
        irq_adc_dac = 1'b0;
        adc_threshold1 = '0;
        adc_threshold2 = '0;
        adc_over_range = '0;
        adc_over_voltage = '0;
        ext_alarm = '0;
        sfp_los = '0;
        sfp_tx_fault = '0;
        sfp_detect_n = '0;
        psu_alarm = 1'b0;
        exp_sticky = '0;
        exp_mask = MASK_RESET[N_IRQ-1:0];
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        start_test("reset state");
        check_value("pl_ps_irq", '0, reg_data_t'(pl_ps_irq));
        bus_read(ADDR_IRQ_MASK, rd);
        check_value("irq_mask", MASK_RESET, rd);
        check_status();
        finish_test();

        start_test("masking and stickiness");
        irq_adc_dac = 1'b1;
        adc_threshold1 = 8'h01;
        ext_alarm = 4'h1;
        sfp_los = 2'b01;
        psu_alarm = 1'b1;
        @(negedge clk);
        {irq_adc_dac, adc_threshold1, sfp_los, psu_alarm} = '0;
        // Alarm held long enough to pass the debouncer
        idle(DEBOUNCE_CYCLES + 4);
        ext_alarm = '0;
        // Let the debouncer and synchronizers drain before unmasking
        idle(DEBOUNCE_CYCLES + 4);
        check_status();
        set_mask('0);
        irq_adc_dac = 1'b1;
        adc_threshold2 = 8'h20;
        @(negedge clk);
        irq_adc_dac = 1'b0;
        adc_threshold2 = '0;
        apply_events(5'b00011, '0);
        idle(3);
        check_status();
        finish_test();

        start_test("write one to clear");
        clear_bits(5'b00001);
        check_status();
        adc_threshold1 = 8'h80;
        clear_bits(5'b00010);
        apply_events(5'b00010, '0);
        check_status();
        adc_threshold1 = '0;
        clear_bits('1);
        check_status();
        finish_test();

        start_test("alarm debounce");
        ext_alarm = 4'h4;
        idle(DEBOUNCE_CYCLES - 4);
        ext_alarm = '0;
        idle(DEBOUNCE_CYCLES + 4);
        check_status();
        ext_alarm = 4'h8;
        seen = 1'b0;
        for (n = 0; n < DEBOUNCE_CYCLES + 4; n++) begin
            @(negedge clk);
            if (pl_ps_irq) seen = 1'b1;
        end
        assert (seen) else begin
            $display("Alarm held for %0d cycles never raised the interrupt",
                     DEBOUNCE_CYCLES + 4);
            errors++;
        end
        ext_alarm = '0;
        apply_events(5'b00100, '0);
        // Debouncer output stays high until the low level is stable
        idle(DEBOUNCE_CYCLES + 2);
        check_status();
        clear_bits('1);
        check_status();
        finish_test();

        start_test("synchronized sources");
        sync_edge_test(IRQ_SFP);
        sync_edge_test(IRQ_PSU);
        finish_test();

        start_test("live status");
        set_mask('1);
        for (n = 0; n < 8; n++) begin
            rnd  = $random(seed);
            rnd2 = $random(seed);
            ext_alarm = rnd[3:0];
            sfp_los = rnd[5:4];
            sfp_tx_fault = rnd[7:6];
            sfp_detect_n = rnd[9:8];
            psu_alarm = rnd[10];
            adc_threshold1 = rnd2[7:0];
            adc_threshold2 = rnd2[15:8];
            adc_over_range = rnd2[23:16];
            adc_over_voltage = rnd2[31:24];
            exp_board = '0;
            exp_board[3:0] = rnd[3:0];
            exp_board[5:4] = rnd[5:4];
            exp_board[7:6] = rnd[7:6];
            exp_board[9:8] = rnd[9:8];
            exp_board[10] = rnd[10];
            exp_adc = rnd2;
            bus_read(ADDR_BOARD_STATUS, rd);
            check_value("board_status", exp_board, rd);
            bus_read(ADDR_ADC_STATUS, rd);
            check_value("adc_status", exp_adc, rd);
        end
        bus_read(8'h24, rd);
        check_value("unmapped", '0, rd);
        finish_test();

        $display("Tests: %0d run, %0d failed, %0d check errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
hdl/irq_pkg.sv
hdl/regmap_pkg.sv
hdl/intr_ctrl_if.sv
hdl/alarm_debounce.sv
hdl/irq_collector.sv
hdl/intr_ctrl_regs.sv
hdl/board_irq_top.sv
testbench/board_irq_tb.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := board_irq_tb
FILELIST  := list.f
OBJDIR    := obj_dir
PASS_MSG  := STATUS: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

$(OBJDIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

sim: $(OBJDIR)/V$(TOP)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
